// ==== dv/IntExecTb.sv ====
// ********************************************************************
// Integer execution subsystem testbench
// Directed tests against a reference register model, with random
// result back-pressure in the last test
// ********************************************************************

module IntExecTb;
    timeunit 1ns;
    timeprecision 100ps;
    import IntExecPkg::*;

    // The tests need about 400 cycles in total
    localparam int CYCLE_LIMIT = 2000;

    logic      clk;
    logic      rstN;
    logic      opValid;
    IssueOp    op;
    logic      opReady;
    logic      resValid;
    ExecResult res;
    logic      resReady;

    DataPath   refRegs [REG_NUM];
    int        inFlight [REG_NUM];
    ExecResult expQ [$];
    ExecResult heldRes;
    logic      stalled;
    logic      randomReady;
    DataPath   nextPc;
    int        seed;
    int        cycleCount;
    int        errorCount;
    int        resultCount;
    int        testErrStart;
    int        testResStart;

    IntExecTop dut (
        .clk      (clk),
        .rstN     (rstN),
        .opValid  (opValid),
        .op       (op),
        .opReady  (opReady),
        .resValid (resValid),
        .res      (res),
        .resReady (resReady)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Result sink with random gaps only while randomReady is set
    initial begin
        int r;
        resReady = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (randomReady) begin
                r = $random(seed);
                resReady = r[0];
            end else begin
                resReady = 1'b1;
            end
        end
    end

    function automatic IssueOp makeOp(IntOpType t, IntAluCode code, CondCode c, RegIdx sa,
                                      RegIdx sb, logic useImm, DataPath imm, RegIdx d);
        IssueOp o;
        o          = '0;
        o.opType   = t;
        o.aluCode  = code;
        o.cond     = c;
        o.srcA     = sa;
        o.srcB     = sb;
        o.useImmB  = useImm;
        o.imm      = imm;
        o.dst      = d;
        o.writeDst = 1'b1;
        o.pc       = nextPc;
        nextPc     = nextPc + 32'd4;
        return o;
    endfunction

    // Reference model of one op against the architectural registers
    function automatic ExecResult predict(IssueOp o);
        DataPath   a;
        DataPath   b;
        DataPath   v;
        logic      hold;
        ExecResult r;
        a = (o.srcA == 0) ? '0 : refRegs[o.srcA];
        b = o.useImmB ? o.imm : ((o.srcB == 0) ? '0 : refRegs[o.srcB]);
        case (o.cond)
            COND_EQ:  hold = (a == b);
            COND_NE:  hold = (a != b);
            COND_LT:  hold = ($signed(a) < $signed(b));
            COND_LTU: hold = (a < b);
            COND_GE:  hold = !($signed(a) < $signed(b));
            COND_GEU: hold = !(a < b);
            default:  hold = 1'b1;
        endcase
        case (o.aluCode)
            ALU_ADD:  v = a + b;
            ALU_SUB:  v = a - b;
            ALU_AND:  v = a & b;
            ALU_OR:   v = a | b;
            ALU_XOR:  v = a ^ b;
            ALU_SLT:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: v = (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  v = a << b[4:0];
            ALU_SRL:  v = a >> b[4:0];
            default:  v = DataPath'($signed(a) >>> b[4:0]);
        endcase
        r          = '0;
        r.dst      = o.dst;
        r.writeDst = o.writeDst;
        r.pc       = o.pc;
        r.isBranch = (o.opType == INT_OP_BR) || (o.opType == INT_OP_JALR);
        r.taken    = (o.opType == INT_OP_JALR) || ((o.opType == INT_OP_BR) && hold);
        r.nextAddr = o.pc + INSN_BYTES;
        if (o.opType == INT_OP_JALR) begin
            r.nextAddr = (a + o.imm) & 32'hFFFF_FFFE;
        end else if (r.taken) begin
            r.nextAddr = o.pc + o.imm;
        end
        if (r.isBranch) begin
            r.data = o.pc + INSN_BYTES;
        end else if (o.opType == INT_OP_SELECT) begin
            r.data = hold ? a : b;
        end else begin
            r.data = v;
        end
        r.mispred = r.isBranch && ((o.predTaken != r.taken) ||
                                   (r.taken && (o.predAddr != r.nextAddr)));
        return r;
    endfunction

    task automatic checkField(input string name, input DataPath got, input DataPath exp);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h (pc %h)", name, got, exp, res.pc);
            errorCount++;
        end
    endtask

    task automatic checkResult();
        ExecResult e;
        if (expQ.size() == 0) begin
            $display("Result for pc %h arrived with no op outstanding", res.pc);
            errorCount++;
        end else begin
            e = expQ.pop_front();
            checkField("res.dst", DataPath'(res.dst), DataPath'(e.dst));
            checkField("res.writeDst", DataPath'(res.writeDst), DataPath'(e.writeDst));
            checkField("res.data", res.data, e.data);
            checkField("res.pc", res.pc, e.pc);
            checkField("res.isBranch", DataPath'(res.isBranch), DataPath'(e.isBranch));
            checkField("res.taken", DataPath'(res.taken), DataPath'(e.taken));
            checkField("res.nextAddr", res.nextAddr, e.nextAddr);
            checkField("res.mispred", DataPath'(res.mispred), DataPath'(e.mispred));
            if (e.writeDst && e.dst != 0) begin
                inFlight[e.dst]--;
            end
            resultCount++;
        end
    endtask

    // Results are checked at the handshake and stalls for a stable res
    always @(posedge clk) begin
        if (rstN && stalled && !resValid) begin
            $display("Result for pc %h was dropped while stalled", heldRes.pc);
            errorCount++;
        end else if (rstN && stalled && res !== heldRes) begin
            $display("Error: res = %h while stalled, held %h", res, heldRes);
            errorCount++;
        end
        stalled = rstN && resValid && !resReady;
        heldRes = res;
        if (rstN && resValid && resReady) begin
            checkResult();
        end
    end

    task automatic issue(input IssueOp o);
        ExecResult e;
        // Hold a second writer of a register until the first retires
        while (o.writeDst && o.dst != 0 && inFlight[o.dst] != 0) begin
            @(posedge clk);
            #1;
        end
        opValid = 1'b1;
        op      = o;
        @(posedge clk);
        while (!opReady) begin
            @(posedge clk);
        end
        #1;
        opValid = 1'b0;
        e = predict(o);
        expQ.push_back(e);
        if (o.writeDst && o.dst != 0) begin
            refRegs[o.dst] = e.data;
            inFlight[o.dst]++;
        end
    endtask

    task automatic loadReg(input RegIdx idx, input DataPath value);
        issue(makeOp(INT_OP_ALU, ALU_ADD, COND_AL, 0, 0, 1'b1, value, idx));
    endtask

    task automatic waitDrain();
        while (expQ.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic markTestStart();
        testErrStart = errorCount;
        testResStart = resultCount;
    endtask

    task automatic reportTest(input string name);
        waitDrain();
        $display("%s: %0d results, %0d errors", name, resultCount - testResStart,
                 errorCount - testErrStart);
    endtask

    task automatic aluAndImmediates();
        markTestStart();
        loadReg(1, 32'd5);
        loadReg(2, 32'hFFFF_FFFD);
        loadReg(3, 32'd5);
        loadReg(4, 32'h0000_2001);
        loadReg(5, 32'h0F0F_00FF);
        for (int c = 0; c <= 6; c++) begin
            issue(makeOp(INT_OP_ALU, IntAluCode'(c), COND_AL, 5, 2, 1'b0, 32'h0, 6));
            issue(makeOp(INT_OP_ALU, IntAluCode'(c), COND_AL, 2, 0, 1'b1, 32'h123, 7));
        end
        // Register 0 stays zero after a write
        issue(makeOp(INT_OP_ALU, ALU_ADD, COND_AL, 1, 0, 1'b1, 32'd9, 0));
        waitDrain();
        issue(makeOp(INT_OP_ALU, ALU_OR, COND_AL, 0, 0, 1'b0, 32'h0, 8));
        reportTest("alu and immediate ops");
    endtask

    task automatic shiftOps();
        markTestStart();
        issue(makeOp(INT_OP_SHIFT, ALU_SLL, COND_AL, 5, 0, 1'b1, 32'd4, 6));
        issue(makeOp(INT_OP_SHIFT, ALU_SRL, COND_AL, 2, 0, 1'b1, 32'd4, 7));
        issue(makeOp(INT_OP_SHIFT, ALU_SRA, COND_AL, 2, 0, 1'b1, 32'd4, 8));
        issue(makeOp(INT_OP_SHIFT, ALU_SRA, COND_AL, 2, 0, 1'b1, 32'hFFFF_FFE3, 9));
        issue(makeOp(INT_OP_SHIFT, ALU_SLL, COND_AL, 5, 1, 1'b0, 32'h0, 10));
        issue(makeOp(INT_OP_SHIFT, ALU_SRL, COND_AL, 5, 0, 1'b1, 32'h0000_0021, 11));
        reportTest("shifts");
    endtask

    task automatic branchResolution();
        IssueOp o;
        int     k;
        markTestStart();
        k = 0;
        for (int c = 0; c <= 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                o = makeOp(INT_OP_BR, ALU_ADD, CondCode'(c), RegIdx'((p == 2) ? 2 : 1),
                           RegIdx'((p == 0) ? 3 : ((p == 1) ? 2 : 1)), 1'b0, 32'h40, 0);
                o.writeDst  = 1'b0;
                // Cycle through right and wrong directions and targets
                o.predTaken = k[0];
                o.predAddr  = k[1] ? o.pc + 32'h40 : o.pc + 32'h8;
                issue(o);
                k++;
            end
        end
        o = makeOp(INT_OP_JALR, ALU_ADD, COND_AL, 4, 0, 1'b0, 32'h10, 9);
        o.predTaken = 1'b1;
        o.predAddr  = 32'h0000_2010;
        issue(o);
        o = makeOp(INT_OP_JALR, ALU_ADD, COND_AL, 4, 0, 1'b0, 32'h10, 9);
        o.predTaken = 1'b1;
        o.predAddr  = 32'h0000_2011;
        issue(o);
        reportTest("branches");
    endtask

    task automatic selectOps();
        markTestStart();
        for (int c = 0; c <= 6; c++) begin
            issue(makeOp(INT_OP_SELECT, ALU_ADD, CondCode'(c), 1, 2, 1'b0, 32'h0,
                         RegIdx'(8 + c % 4)));
        end
        reportTest("select");
    endtask

    task automatic dependencyChain();
        RegIdx prev;
        RegIdx d;
        markTestStart();
        prev = 1;
        for (int i = 0; i < 12; i++) begin
            d = RegIdx'(10 + i % 3);
            if (i % 3 == 2) begin
                issue(makeOp(INT_OP_ALU, ALU_ADD, COND_AL, prev, prev, 1'b0, 32'h0, d));
            end else begin
                issue(makeOp(INT_OP_ALU, (i % 2) ? ALU_XOR : ALU_SUB, COND_AL, prev, 0,
                             1'b1, DataPath'(i * 7 + 1), d));
            end
            prev = d;
        end
        reportTest("dependency chain");
    endtask

    task automatic backPressure();
        IntAluCode code;
        markTestStart();
        randomReady = 1'b1;
        for (int i = 0; i < 20; i++) begin
            code = IntAluCode'(i % 10);
            issue(makeOp((code >= ALU_SLL) ? INT_OP_SHIFT : INT_OP_ALU, code, COND_AL,
                         RegIdx'(1 + i % 5), RegIdx'(1 + (i + 2) % 5), 1'b0, 32'h0,
                         RegIdx'(1 + (i + 3) % 6)));
        end
        waitDrain();
        randomReady = 1'b0;
        reportTest("back-pressure");
    endtask

    initial begin
        seed        = 79;
        rstN        = 1'b0;
        opValid     = 1'b0;
        op          = '0;
        randomReady = 1'b0;
        stalled     = 1'b0;
        nextPc      = 32'h0000_1000;
        cycleCount  = 0;
        errorCount  = 0;
        resultCount = 0;
        for (int i = 0; i < REG_NUM; i++) begin
            refRegs[i]  = '0;
            inFlight[i] = 0;
        end
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        if (!opReady || resValid) begin
            $display("Error: after reset opReady = %h, resValid = %h", opReady, resValid);
            errorCount++;
        end
        aluAndImmediates();
        shiftOps();
        branchResolution();
        selectOps();
        dependencyChain();
        backPressure();
        $display("Summary: %0d results checked, %0d errors", resultCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== hw/ExecQueue.sv ====
// ********************************************************************
// Execution queue
// Four-entry circular FIFO of read ops, valid/ready on both sides
// ********************************************************************

module ExecQueue (
    input  logic              clk,
    input  logic              rstN,
    input  logic              inValid,
    input  IntExecPkg::ReadOp inOp,
    output logic              inReady,
    output logic              outValid,
    output IntExecPkg::ReadOp outOp,
    input  logic              outReady
);
    import IntExecPkg::*;

    ReadOp                      mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_WIDTH-1:0] wrPtr;
    logic [QUEUE_PTR_WIDTH-1:0] rdPtr;
    logic [QUEUE_CNT_WIDTH-1:0] count;
    logic                       push;
    logic                       pop;

    assign inReady  = (count != QUEUE_CNT_WIDTH'(QUEUE_DEPTH));
    assign outValid = (count != '0);
    assign outOp    = mem[rdPtr];

    assign push = inValid && inReady;
    assign pop  = outValid && outReady;

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inOp;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        count <= QUEUE_CNT_WIDTH'(QUEUE_DEPTH));

endmodule

// ==== hw/IntAlu.sv ====
// ********************************************************************
// Integer ALU
// Add, subtract, logic, set-less-than and the three shifts
// ********************************************************************

module IntAlu (
    input  IntExecPkg::IntAluCode aluCode,
    input  IntExecPkg::DataPath   opA,
    input  IntExecPkg::DataPath   opB,
    output IntExecPkg::DataPath   result
);
    import IntExecPkg::*;

    logic [SHIFT_AMT_WIDTH-1:0] shamt;
    logic                       ltSigned;
    logic                       ltUnsigned;

    // Upper bits of opB are ignored by the shifts
    assign shamt      = opB[SHIFT_AMT_WIDTH-1:0];
    assign ltSigned   = ($signed(opA) < $signed(opB));
    assign ltUnsigned = (opA < opB);

    always_comb begin
        case (aluCode)
            ALU_ADD: begin
                result = opA + opB;
            end
            ALU_SUB: begin
                result = opA - opB;
            end
            ALU_AND: begin
                result = opA & opB;
            end
            ALU_OR: begin
                result = opA | opB;
            end
            ALU_XOR: begin
                result = opA ^ opB;
            end
            ALU_SLT: begin
                result = DataPath'(ltSigned);
            end
            ALU_SLTU: begin
                result = DataPath'(ltUnsigned);
            end
            ALU_SLL: begin
                result = opA << shamt;
            end
            ALU_SRL: begin
                result = opA >> shamt;
            end
            ALU_SRA: begin
                result = DataPath'($signed(opA) >>> shamt);
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== hw/IntExecPkg.sv ====
// ********************************************************************
// Integer execution package
// Widths, depths, opcode enums and the op and result structs shared
// by the register read, queue and execution blocks
// ********************************************************************

package IntExecPkg;

    // Datapath and register file sizes
    localparam int DATA_WIDTH      = 32;
    localparam int REG_NUM         = 16;
    localparam int REG_IDX_WIDTH   = 4;
    localparam int SHIFT_AMT_WIDTH = 5;

    // Execution queue geometry
    localparam int QUEUE_DEPTH     = 4;
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

    // Fall-through step of the PC
    localparam int INSN_BYTES      = 4;

    typedef logic [DATA_WIDTH-1:0]    DataPath;
    typedef logic [REG_IDX_WIDTH-1:0] RegIdx;

    typedef enum logic [2:0] {
        INT_OP_ALU    = 3'd0,
        INT_OP_SHIFT  = 3'd1,
        INT_OP_BR     = 3'd2,
        INT_OP_JALR   = 3'd3,
        INT_OP_SELECT = 3'd4
    } IntOpType;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } IntAluCode;

    typedef enum logic [2:0] {
        COND_EQ  = 3'd0,
        COND_NE  = 3'd1,
        COND_LT  = 3'd2,
        COND_LTU = 3'd3,
        COND_GE  = 3'd4,
        COND_GEU = 3'd5,
        COND_AL  = 3'd6
    } CondCode;

    // Op as it arrives from outside
    typedef struct packed {
        IntOpType  opType;
        IntAluCode aluCode;
        CondCode   cond;
        RegIdx     srcA;
        RegIdx     srcB;
        logic      useImmB;
        DataPath   imm;
        RegIdx     dst;
        logic      writeDst;
        DataPath   pc;
        logic      predTaken;
        DataPath   predAddr;
    } IssueOp;

    // Op with its operands, immediate already folded into opB
    typedef struct packed {
        IntOpType  opType;
        IntAluCode aluCode;
        CondCode   cond;
        DataPath   imm;
        RegIdx     dst;
        logic      writeDst;
        DataPath   pc;
        logic      predTaken;
        DataPath   predAddr;
        DataPath   opA;
        DataPath   opB;
    } ReadOp;

    typedef struct packed {
        RegIdx     dst;
        logic      writeDst;
        DataPath   data;
        DataPath   pc;
        logic      isBranch;
        logic      taken;
        DataPath   nextAddr;
        logic      mispred;
    } ExecResult;

endpackage

// ==== hw/IntExecStage.sv ====
// ********************************************************************
// Integer execution stage
// Result select, branch resolution and misprediction check, with a
// one-entry output register that also drives writeback
// ********************************************************************

module IntExecStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  headValid,
    input  IntExecPkg::ReadOp     headOp,
    output logic                  headReady,
    output logic                  resValid,
    output IntExecPkg::ExecResult res,
    input  logic                  resReady,
    output logic                  wbValid,
    output IntExecPkg::RegIdx     wbDst,
    output IntExecPkg::DataPath   wbData
);
    import IntExecPkg::*;

    function automatic logic condHolds(CondCode cond, DataPath a, DataPath b);
        logic holds;
        case (cond)
            COND_EQ:  holds = (a == b);
            COND_NE:  holds = (a != b);
            COND_LT:  holds = ($signed(a) < $signed(b));
            COND_LTU: holds = (a < b);
            COND_GE:  holds = ($signed(a) >= $signed(b));
            COND_GEU: holds = (a >= b);
            default:  holds = 1'b1;
        endcase
        return holds;
    endfunction

    DataPath   aluResult;
    logic      condOk;
    logic      isBranch;
    logic      taken;
    DataPath   fallThrough;
    DataPath   target;
    ExecResult nextRes;
    logic      load;

    IntAlu alu (
        .aluCode (headOp.aluCode),
        .opA     (headOp.opA),
        .opB     (headOp.opB),
        .result  (aluResult)
    );

    always_comb begin
        condOk      = condHolds(headOp.cond, headOp.opA, headOp.opB);
        fallThrough = headOp.pc + DataPath'(INSN_BYTES);
        isBranch    = (headOp.opType == INT_OP_BR) || (headOp.opType == INT_OP_JALR);

        // JALR always jumps, BR follows its condition
        taken = (headOp.opType == INT_OP_JALR) || ((headOp.opType == INT_OP_BR) && condOk);

        if (headOp.opType == INT_OP_JALR) begin
            target = (headOp.opA + headOp.imm) & ~DataPath'(1);
        end else begin
            target = headOp.pc + headOp.imm;
        end

        nextRes.dst      = headOp.dst;
        nextRes.writeDst = headOp.writeDst;
        nextRes.pc       = headOp.pc;
        nextRes.isBranch = isBranch;
        nextRes.taken    = taken;
        nextRes.nextAddr = taken ? target : fallThrough;

        case (headOp.opType)
            INT_OP_ALU, INT_OP_SHIFT: nextRes.data = aluResult;
            INT_OP_BR, INT_OP_JALR:   nextRes.data = fallThrough;
            default:                  nextRes.data = condOk ? headOp.opA : headOp.opB;
        endcase

        // Wrong direction, or right direction but wrong target
        nextRes.mispred = isBranch &&
            ((headOp.predTaken != taken) ||
             (taken && (headOp.predAddr != nextRes.nextAddr)));
    end

    assign headReady = !resValid || resReady;
    assign load      = headValid && headReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resValid <= 1'b0;
        end else if (load) begin
            resValid <= 1'b1;
        end else if (resReady) begin
            resValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            res <= nextRes;
        end
    end

    // Writeback rides on the output handshake
    assign wbValid = resValid && resReady && res.writeDst;
    assign wbDst   = res.dst;
    assign wbData  = res.data;

    assert property (@(posedge clk) disable iff (!rstN)
        (resValid && !resReady) |=> (resValid && $stable(res)));

endmodule

// ==== hw/IntExecTop.sv ====
// ********************************************************************
// Integer execution subsystem top
// Register read stage, execution queue and execution stage
// ********************************************************************

module IntExecTop (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  opValid,
    input  IntExecPkg::IssueOp    op,
    output logic                  opReady,
    output logic                  resValid,
    output IntExecPkg::ExecResult res,
    input  logic                  resReady
);
    import IntExecPkg::*;

    logic    readValid;
    logic    readReady;
    ReadOp   readOp;

    logic    headValid;
    logic    headReady;
    ReadOp   headOp;

    // Writeback path back to the register file
    logic    wbValid;
    RegIdx   wbDst;
    DataPath wbData;

    IntRegReadStage regRead (
        .clk       (clk),
        .rstN      (rstN),
        .opValid   (opValid),
        .op        (op),
        .opReady   (opReady),
        .readValid (readValid),
        .readOp    (readOp),
        .readReady (readReady),
        .wbValid   (wbValid),
        .wbDst     (wbDst),
        .wbData    (wbData)
    );

    ExecQueue queue (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (readValid),
        .inOp     (readOp),
        .inReady  (readReady),
        .outValid (headValid),
        .outOp    (headOp),
        .outReady (headReady)
    );

    IntExecStage exec (
        .clk       (clk),
        .rstN      (rstN),
        .headValid (headValid),
        .headOp    (headOp),
        .headReady (headReady),
        .resValid  (resValid),
        .res       (res),
        .resReady  (resReady),
        .wbValid   (wbValid),
        .wbDst     (wbDst),
        .wbData    (wbData)
    );

endmodule

// ==== hw/IntRegReadStage.sv ====
// ********************************************************************
// Integer register read stage
// Register file, busy-bit scoreboard and operand read feeding a
// one-entry output register
// ********************************************************************

module IntRegReadStage (
    input  logic                clk,
    input  logic                rstN,
    input  logic                opValid,
    input  IntExecPkg::IssueOp  op,
    output logic                opReady,
    output logic                readValid,
    output IntExecPkg::ReadOp   readOp,
    input  logic                readReady,
    input  logic                wbValid,
    input  IntExecPkg::RegIdx   wbDst,
    input  IntExecPkg::DataPath wbData
);
    import IntExecPkg::*;

    DataPath            regFile [REG_NUM];
    logic [REG_NUM-1:0] busy;

    logic    srcABusy;
    logic    srcBBusy;
    logic    outFree;
    logic    accept;
    DataPath srcAVal;
    DataPath srcBVal;
    ReadOp   nextRead;

    // Only registered busy bits count, so a dependent op waits one edge
    // past its producer's writeback
    assign srcABusy = busy[op.srcA];
    assign srcBBusy = !op.useImmB && busy[op.srcB];
    assign outFree  = !readValid || readReady;
    assign opReady  = !srcABusy && !srcBBusy && outFree;
    assign accept   = opValid && opReady;

    always_comb begin
        srcAVal = (op.srcA == '0) ? '0 : regFile[op.srcA];
        srcBVal = (op.srcB == '0) ? '0 : regFile[op.srcB];

        nextRead.opType    = op.opType;
        nextRead.aluCode   = op.aluCode;
        nextRead.cond      = op.cond;
        nextRead.imm       = op.imm;
        nextRead.dst       = op.dst;
        nextRead.writeDst  = op.writeDst;
        nextRead.pc        = op.pc;
        nextRead.predTaken = op.predTaken;
        nextRead.predAddr  = op.predAddr;
        nextRead.opA       = srcAVal;
        nextRead.opB       = op.useImmB ? op.imm : srcBVal;
    end

    // Register file and scoreboard
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regFile[i] <= '0;
            end
            busy <= '0;
        end else begin
            if (wbValid && wbDst != '0) begin
                regFile[wbDst] <= wbData;
                busy[wbDst]    <= 1'b0;
            end
            // Set after clear so a same-edge reuse of dst stays busy
            if (accept && op.writeDst && op.dst != '0) begin
                busy[op.dst] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readValid <= 1'b0;
        end else if (accept) begin
            readValid <= 1'b1;
        end else if (readReady) begin
            readValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            readOp <= nextRead;
        end
    end

    // Writeback must retire an op that this stage marked busy
    assert property (@(posedge clk) disable iff (!rstN)
        (wbValid && wbDst != '0) |-> busy[wbDst]);

    // No second producer for a register still in flight
    assert property (@(posedge clk) disable iff (!rstN)
        (accept && op.writeDst && op.dst != '0)
            |-> (!busy[op.dst] || (wbValid && wbDst == op.dst)));

endmodule

// ==== src.f ====
hw/IntExecPkg.sv
hw/IntAlu.sv
hw/IntRegReadStage.sv
hw/ExecQueue.sv
hw/IntExecStage.sv
hw/IntExecTop.sv
dv/IntExecTb.sv
